// ==== rtl/full_mat_consts.svh ====
// ========================================
// vector transform engine sizes
// ========================================

`ifndef FULL_MAT_CONSTS_SVH
`define FULL_MAT_CONSTS_SVH

// elements are Q1.14
`define FM_DATA_W 16
`define FM_FRAC 14

`define FM_FRAME_LEN 91
`define FM_POS_W 7

// 0..8 matrix row-major, 9..11 gains, 12..15 unused
`define FM_ADDR_W 4
`define FM_GAIN_BASE 9

`define FM_LAT 4

`endif

// ==== rtl/full_mat_pkg.sv ====
// ========================================
// vector transform engine types
// ========================================

`include "full_mat_consts.svh"

package full_mat_pkg;

	typedef enum logic [1:0] {
		OP_SUM = 2'd0,
		OP_DIFF = 2'd1,
		OP_MAT = 2'd2,
		OP_GAIN = 2'd3
	} combine_op_e;

	typedef logic signed [`FM_DATA_W-1:0] elem_t;
	typedef elem_t [2:0] vec_t;

	typedef struct packed {
		logic vld;
		combine_op_e op;
		vec_t vec;
	} sample_t;

	typedef struct packed {
		logic wr;
		logic [`FM_ADDR_W-1:0] addr;
		elem_t data;
	} coef_wr_t;

	// what each unit hands to the combiner
	typedef struct packed {
		logic vld;
		combine_op_e op;
		vec_t vec;
	} part_t;

	typedef struct packed {
		logic vld;
		logic [`FM_POS_W-1:0] pos;
		logic frame_start;
		vec_t vec;
	} result_t;

	// wide enough for a row sum of three full products
	localparam int SAT_IN_W = 2 * `FM_DATA_W + 4;
	localparam logic signed [SAT_IN_W-1:0] ELEM_MAX = SAT_IN_W'(2 ** (`FM_DATA_W - 1) - 1);
	localparam logic signed [SAT_IN_W-1:0] ELEM_MIN = -ELEM_MAX - 1;

	// clamp a wide signed value to one element
	function automatic elem_t sat_elem(input logic signed [SAT_IN_W-1:0] x);
		if (x > ELEM_MAX)
			return ELEM_MAX[`FM_DATA_W-1:0];
		else if (x < ELEM_MIN)
			return ELEM_MIN[`FM_DATA_W-1:0];
		return x[`FM_DATA_W-1:0];
	endfunction

endpackage

// ==== rtl/mat_mult.sv ====
// ========================================
// 3x3 matrix times vector
// ========================================

`timescale 1ns/1ps

`include "full_mat_consts.svh"

module mat_mult import full_mat_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic en,
	input sample_t in,
	input coef_wr_t coef,
	output part_t part
);

	// matrix fills every address below the gains
	localparam int N_COEF = `FM_GAIN_BASE;
	localparam int PROD_W = 2 * `FM_DATA_W;
	localparam int SUM_W = PROD_W + 2;

	elem_t coef_q [N_COEF];

	logic s1_vld;
	logic s2_vld;
	logic s3_vld;
	combine_op_e s1_op;
	combine_op_e s2_op;
	combine_op_e s3_op;

	logic signed [PROD_W-1:0] prod_q [N_COEF];
	logic signed [SUM_W-1:0] row_sum_q [3];
	vec_t res_q;

	// ========================================
	// coefficient registers
	// ========================================

	// writes land regardless of en
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < N_COEF; i++)
				coef_q[i] <= '0;
		end else if (coef.wr && coef.addr < `FM_ADDR_W'(N_COEF)) begin
			coef_q[coef.addr] <= coef.data;
		end
	end

	// ========================================
	// product, row sum, saturate
	// ========================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
			s3_vld <= 1'b0;
		end else if (en) begin
			s1_vld <= in.vld;
			s2_vld <= s1_vld;
			s3_vld <= s2_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (en) begin
			s1_op <= in.op;
			s2_op <= s1_op;
			s3_op <= s2_op;
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					prod_q[3*r+c] <= PROD_W'($signed(in.vec[c])) * PROD_W'(coef_q[3*r+c]);
				end
			end
			for (int r = 0; r < 3; r++) begin
				row_sum_q[r] <= SUM_W'(prod_q[3*r]) + SUM_W'(prod_q[3*r+1])
					+ SUM_W'(prod_q[3*r+2]);
			end
			// back to Q1.14
			for (int r = 0; r < 3; r++) begin
				res_q[r] <= sat_elem(SAT_IN_W'(row_sum_q[r] >>> `FM_FRAC));
			end
		end
	end

	assign part = '{vld: s3_vld, op: s3_op, vec: res_q};

	// a sample in flight does not survive reset
	a_vld_after_rst: assert property (@(posedge clk) !rst_n |=> !part.vld)
		else $error("mat_mult: part.vld high after reset");

	a_hold_on_en_low: assert property (
		@(posedge clk) disable iff (!rst_n) !en |=> $stable(part)
	) else $error("mat_mult: part moved while en was low");

endmodule

// ==== rtl/array_mult.sv ====
// ========================================
// element-wise gain multiply
// ========================================

`timescale 1ns/1ps

`include "full_mat_consts.svh"

module array_mult import full_mat_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic en,
	input sample_t in,
	input coef_wr_t coef,
	output part_t part
);

	localparam int PROD_W = 2 * `FM_DATA_W;

	elem_t gain_q [3];

	logic s1_vld;
	logic s2_vld;
	logic s3_vld;
	logic signed [PROD_W-1:0] prod_q [3];
	vec_t res_q;
	vec_t align_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int g = 0; g < 3; g++)
				gain_q[g] <= '0;
		end else if (coef.wr) begin
			for (int g = 0; g < 3; g++) begin
				if (coef.addr == `FM_ADDR_W'(`FM_GAIN_BASE + g))
					gain_q[g] <= coef.data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_vld <= 1'b0;
			s2_vld <= 1'b0;
			s3_vld <= 1'b0;
		end else if (en) begin
			s1_vld <= in.vld;
			s2_vld <= s1_vld;
			s3_vld <= s2_vld;
		end
	end

	// third stage only lines the gains up with the matrix rows
	always_ff @(posedge clk) begin
		if (en) begin
			for (int e = 0; e < 3; e++) begin
				prod_q[e] <= PROD_W'($signed(in.vec[e])) * PROD_W'(gain_q[e]);
				res_q[e] <= sat_elem(SAT_IN_W'(prod_q[e] >>> `FM_FRAC));
			end
			align_q <= res_q;
		end
	end

	assign part = '{vld: s3_vld, op: combine_op_e'(2'd0), vec: align_q};

	a_addr_in_map: assert property (
		@(posedge clk) disable iff (!rst_n)
		coef.wr |-> coef.addr < `FM_ADDR_W'(`FM_GAIN_BASE + 3)
	) else $error("array_mult: coefficient write to unused address %0d", coef.addr);

endmodule

// ==== rtl/mat_combine.sv ====
// ========================================
// combine, saturate and tag position
// ========================================

`timescale 1ns/1ps

`include "full_mat_consts.svh"

module mat_combine import full_mat_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic en,
	input part_t mat_part,
	input part_t gain_part,
	output result_t out
);

	// one extra bit holds any sum or difference of two elements
	localparam int SUM_W = `FM_DATA_W + 1;
	localparam logic [`FM_POS_W-1:0] POS_LAST = `FM_POS_W'(`FM_FRAME_LEN - 1);

	vec_t comb_vec;

	logic vld_q;
	logic fs_q;
	logic [`FM_POS_W-1:0] pos_q;
	logic [`FM_POS_W-1:0] pos_cnt;
	vec_t vec_q;

	// ========================================
	// per-element combine
	// ========================================

	always_comb begin
		logic signed [SUM_W-1:0] a;
		logic signed [SUM_W-1:0] b;
		logic signed [SUM_W-1:0] r;
		for (int e = 0; e < 3; e++) begin
			a = SUM_W'($signed(mat_part.vec[e]));
			b = SUM_W'($signed(gain_part.vec[e]));
			// op rides with the matrix side
			case (mat_part.op)
				OP_SUM: r = a + b;
				OP_DIFF: r = a - b;
				OP_MAT: r = a;
				OP_GAIN: r = b;
				default: r = a;
			endcase
			comb_vec[e] = sat_elem(SAT_IN_W'(r));
		end
	end

	// ========================================
	// output register and frame position
	// ========================================

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			vld_q <= 1'b0;
			fs_q <= 1'b0;
			pos_q <= '0;
			pos_cnt <= '0;
		end else if (en) begin
			vld_q <= mat_part.vld;
			fs_q <= mat_part.vld && (pos_cnt == '0);
			if (mat_part.vld) begin
				pos_q <= pos_cnt;
				if (pos_cnt == POS_LAST)
					pos_cnt <= '0;
				else
					pos_cnt <= pos_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (en)
			vec_q <= comb_vec;
	end

	assign out = '{vld: vld_q, pos: pos_q, frame_start: fs_q, vec: vec_q};

	// both units must deliver the same sample on the same cycle
	a_parts_aligned: assert property (
		@(posedge clk) disable iff (!rst_n) mat_part.vld == gain_part.vld
	) else $error("mat_combine: unit outputs out of step, mat %b gain %b",
		mat_part.vld, gain_part.vld);

endmodule

// ==== rtl/full_mat.sv ====
// ========================================
// vector transform engine top
// ========================================

`timescale 1ns/1ps

module full_mat import full_mat_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic en,
	input sample_t in,
	input coef_wr_t coef,
	output result_t out
);

	part_t mat_part;
	part_t gain_part;

	// both units see every sample and every write
	mat_mult mat_mult_i (
		.clk (clk),
		.rst_n (rst_n),
		.en (en),
		.in (in),
		.coef (coef),
		.part (mat_part)
	);

	array_mult array_mult_i (
		.clk (clk),
		.rst_n (rst_n),
		.en (en),
		.in (in),
		.coef (coef),
		.part (gain_part)
	);

	mat_combine mat_combine_i (
		.clk (clk),
		.rst_n (rst_n),
		.en (en),
		.mat_part (mat_part),
		.gain_part (gain_part),
		.out (out)
	);

endmodule

// ==== bench/full_mat_tb.sv ====
// ========================================
// vector transform engine testbench
// ========================================

`timescale 1ns/1ps

`include "full_mat_consts.svh"

module full_mat_tb import full_mat_pkg::*; ();

	logic clk;
	logic rst_n;
	logic en;
	sample_t in;
	coef_wr_t coef;
	result_t out;

	int errors = 0;
	int timeouts = 0;

	// reference coefficients, frame position and expected pipeline
	elem_t m_coef [9];
	elem_t m_gain [3];
	int model_pos = 0;
	result_t exp_q [$];
	result_t exp_out = '0;
	result_t next_exp;

	full_mat dut_i (
		.clk (clk),
		.rst_n (rst_n),
		.en (en),
		.in (in),
		.coef (coef),
		.out (out)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ========================================
	// reference model
	// ========================================

	function automatic elem_t clamp_elem(input longint x);
		longint lim;
		lim = (longint'(1) << (`FM_DATA_W - 1)) - 1;
		if (x > lim)
			return elem_t'(lim);
		if (x < -lim - 1)
			return elem_t'(-lim - 1);
		return elem_t'(x);
	endfunction

	function automatic vec_t expected_vec(input sample_t s);
		longint acc;
		longint comb;
		elem_t mrow;
		elem_t gprod;
		vec_t res;
		for (int i = 0; i < 3; i++) begin
			acc = 0;
			for (int c = 0; c < 3; c++)
				acc += longint'(m_coef[3*i+c]) * longint'($signed(s.vec[c]));
			mrow = clamp_elem(acc >>> `FM_FRAC);
			gprod = clamp_elem((longint'($signed(s.vec[i])) * longint'(m_gain[i])) >>> `FM_FRAC);
			case (s.op)
				OP_SUM: comb = longint'(mrow) + longint'(gprod);
				OP_DIFF: comb = longint'(mrow) - longint'(gprod);
				OP_MAT: comb = longint'(mrow);
				default: comb = longint'(gprod);
			endcase
			res[i] = clamp_elem(comb);
		end
		return res;
	endfunction

	// the queue takes one entry per enabled cycle and its head is what out should show
	always @(posedge clk) begin
		if (!rst_n) begin
			exp_q.delete();
			for (int i = 0; i < `FM_LAT - 1; i++)
				exp_q.push_back('0);
			model_pos = 0;
			exp_out <= '0;
		end else if (en) begin
			next_exp = '0;
			next_exp.vld = in.vld;
			if (in.vld) begin
				next_exp.vec = expected_vec(in);
				next_exp.pos = `FM_POS_W'(model_pos);
				next_exp.frame_start = (model_pos == 0);
				model_pos = (model_pos == `FM_FRAME_LEN - 1) ? 0 : model_pos + 1;
			end
			exp_q.push_back(next_exp);
			if (exp_q.size() > `FM_LAT)
				void'(exp_q.pop_front());
			exp_out <= exp_q[0];
		end
	end

	// ========================================
	// checks
	// ========================================

	a_out_vld: assert property (@(posedge clk) disable iff (!rst_n) out.vld == exp_out.vld)
	else begin
		errors++;
		$display("CHECK FAILED: out.vld got %h expected %h",
			$sampled(out.vld), $sampled(exp_out.vld));
	end

	a_frame_start: assert property (
		@(posedge clk) disable iff (!rst_n) out.frame_start == exp_out.frame_start
	) else begin
		errors++;
		$display("CHECK FAILED: out.frame_start got %h expected %h",
			$sampled(out.frame_start), $sampled(exp_out.frame_start));
	end

	a_out_vec: assert property (
		@(posedge clk) disable iff (!rst_n) out.vld |-> out.vec == exp_out.vec
	) else begin
		errors++;
		$display("CHECK FAILED: out.vec got %h expected %h",
			$sampled(out.vec), $sampled(exp_out.vec));
	end

	a_out_pos: assert property (
		@(posedge clk) disable iff (!rst_n) out.vld |-> out.pos == exp_out.pos
	) else begin
		errors++;
		$display("CHECK FAILED: out.pos got %h expected %h",
			$sampled(out.pos), $sampled(exp_out.pos));
	end

	a_start_at_zero: assert property (
		@(posedge clk) disable iff (!rst_n) out.vld |-> out.frame_start == (out.pos == '0)
	) else begin
		errors++;
		$display("CHECK FAILED: out.frame_start %h with out.pos %h",
			$sampled(out.frame_start), $sampled(out.pos));
	end

	// ========================================
	// stimulus
	// ========================================

	// every task starts and ends 1 ns after a rising edge
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic write_coef(input int addr, input elem_t data);
		coef = '{wr: 1'b1, addr: `FM_ADDR_W'(addr), data: data};
		tick();
		coef.wr = 1'b0;
		if (addr < `FM_GAIN_BASE)
			m_coef[addr] = data;
		else
			m_gain[addr - `FM_GAIN_BASE] = data;
	endtask

	task automatic drive_cycle(input logic vld, input combine_op_e op, input vec_t v,
		input logic en_lvl);
		in = '{vld: vld, op: op, vec: v};
		en = en_lvl;
		tick();
	endtask

	function automatic vec_t rand_vec();
		vec_t v;
		for (int e = 0; e < 3; e++)
			v[e] = elem_t'($urandom());
		return v;
	endfunction

	function automatic combine_op_e rand_op();
		return combine_op_e'(2'($urandom_range(3, 0)));
	endfunction

	// busy while the model or the DUT still has a valid sample in flight
	function automatic logic pipe_busy();
		foreach (exp_q[i])
			if (exp_q[i].vld)
				return 1'b1;
		return exp_out.vld || out.vld;
	endfunction

	task automatic wait_drain(input int max_cycles);
		int n;
		n = 0;
		in.vld = 1'b0;
		en = 1'b1;
		while (pipe_busy() && n < max_cycles) begin
			tick();
			n++;
		end
		if (pipe_busy()) begin
			timeouts++;
			$display("timeout: pipeline still busy after %0d cycles", max_cycles);
		end
	endtask

	// full scale, or within +/- 0.5 when narrow
	task automatic load_random_coefs(input logic narrow);
		for (int a = 0; a < `FM_GAIN_BASE + 3; a++) begin
			if (narrow)
				write_coef(a, elem_t'(int'($urandom_range(16383, 0)) - 8192));
			else
				write_coef(a, elem_t'($urandom()));
		end
	endtask

	initial begin
		vec_t v;
		void'($urandom(32'h4cec));
		rst_n = 1'b0;
		en = 1'b0;
		in = '0;
		coef = '0;
		foreach (m_coef[i])
			m_coef[i] = '0;
		foreach (m_gain[i])
			m_gain[i] = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		en = 1'b1;
		repeat (6) tick();

		// identity matrix, zero gains
		for (int a = 0; a < `FM_GAIN_BASE; a++)
			write_coef(a, (a % 4 == 0) ? elem_t'(1 << `FM_FRAC) : elem_t'(0));
		for (int i = 0; i < 10; i++)
			drive_cycle(1'b1, OP_MAT, rand_vec(), 1'b1);
		wait_drain(20);

		// back to back, all opcodes
		load_random_coefs(1'b0);
		for (int i = 0; i < 40; i++)
			drive_cycle(1'b1, rand_op(), rand_vec(), 1'b1);
		wait_drain(20);

		// en dropped for random stretches mid-stream
		load_random_coefs(1'b1);
		for (int i = 0; i < 40; i++) begin
			drive_cycle($urandom_range(3, 0) != 0, rand_op(), rand_vec(), 1'b1);
			if ($urandom_range(2, 0) == 0) begin
				repeat ($urandom_range(5, 1))
					drive_cycle(1'b1, rand_op(), rand_vec(), 1'b0);
			end
		end
		wait_drain(20);

		// full-scale negative everywhere
		for (int a = 0; a < `FM_GAIN_BASE + 3; a++)
			write_coef(a, elem_t'(16'sh8000));
		for (int e = 0; e < 3; e++)
			v[e] = elem_t'(16'sh8000);
		for (int o = 0; o < 4; o++)
			drive_cycle(1'b1, combine_op_e'(2'(o)), v, 1'b1);
		wait_drain(20);

		// identity against a gain of -1.0, opposite extremes
		for (int a = 0; a < `FM_GAIN_BASE; a++)
			write_coef(a, (a % 4 == 0) ? elem_t'(1 << `FM_FRAC) : elem_t'(0));
		for (int g = 0; g < 3; g++)
			write_coef(`FM_GAIN_BASE + g, elem_t'(-(1 << `FM_FRAC)));
		v[0] = elem_t'(16'sh7fff);
		v[1] = elem_t'(16'sh8000);
		v[2] = elem_t'(16'sh7fff);
		for (int o = 0; o < 4; o++)
			drive_cycle(1'b1, combine_op_e'(2'(o)), v, 1'b1);
		wait_drain(20);

		// long stream carries the frame position past several wraps
		load_random_coefs(1'b1);
		for (int i = 0; i < 150; i++)
			drive_cycle(1'b1, rand_op(), rand_vec(), 1'b1);
		wait_drain(20);

		repeat (4) tick();
		$display("checks failed: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/full_mat_pkg.sv
rtl/mat_mult.sv
rtl/array_mult.sv
rtl/mat_combine.sv
rtl/full_mat.sv
bench/full_mat_tb.sv

// ==== Makefile ====
# Verilator build and run for the vector transform engine

VERILATOR ?= verilator
TOP ?= full_mat_tb
FILELIST ?= verilog.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing --assert
JOBS ?= 0

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the simulation printed the pass line
run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
